//--- Bender.yml
package:
  name: fv_bank

sources:
  - fv_pkg.sv
  - fv_sram_bank.sv
  - fv_bank_ctrl.sv
  - fv_stream_buffer.sv
  - fv_edge_router.sv
  - fv_bank_top.sv
  - target: test
    files:
      - fv_bank_tb.sv

//--- fv_bank_ctrl.sv
/* Requests and stream starts arriving while busy are dropped; there is no
   back-pressure. A node uses ceil(fv_num/2) lines, fv_num sampled at the start. */
module fv_bank_ctrl
    import fv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      update_phase,
    input  logic      stream_begin,
    input  fv_count_t fv_num,
    input  iter_t     cur_replay_iter,
    input  logic      req_valid,
    input  logic      req_write,
    input  logic      req_last,
    input  node_id_t  req_node_id,
    input  pe_tag_t   req_pe_tag,
    input  fv_line_t  req_data,
    input  fv_line_t  sram_rdata,
    output logic      sram_cen,
    output logic      sram_wen,
    output fv_addr_t  sram_addr,
    output fv_line_t  sram_wdata,
    output logic      stream_valid,
    output logic      stream_sos,
    output logic      stream_eos,
    output buf_addr_t stream_addr,
    output fv_line_t  stream_data,
    output logic      rd_valid,
    output logic      rd_sos,
    output logic      rd_eos,
    output pe_tag_t   rd_tag,
    output fv_line_t  rd_data
);

    bank_state_t state, nx_state;

    // Next line and node to issue
    line_idx_t line_cnt, nx_line;
    logic [$clog2(NODES_PER_ITER)-1:0] node_cnt, nx_node;

    logic [$clog2(LINES_PER_NODE):0] lines_in, lines_q, lines_cur;
    fv_count_t fv_num_p1;

    node_id_t node_q;
    pe_tag_t  tag_q;
    iter_t    last_iter_q;

    // Access issued this cycle
    logic      issue_rd;
    logic      issue_wr;
    node_id_t  issue_node;
    line_idx_t issue_line;
    logic [$clog2(NODES_PER_ITER)-1:0] issue_idx;
    logic      line_last;
    logic      beat_last_d;

    // Attributes of the read issued last cycle, whose data arrives now
    logic      beat_first_q;
    logic      beat_last_q;
    buf_addr_t beat_buf_q;

    // ceil(fv_num/2)
    assign fv_num_p1 = fv_num + 1'b1;
    assign lines_in  = fv_num_p1[$bits(fv_count_t)-1:1];
    assign lines_cur = (state == IDLE) ? lines_in : lines_q;

    assign line_last = ({1'b0, issue_line} == lines_cur - 1'b1);

    always_comb begin
        nx_state   = state;
        issue_rd   = 1'b0;
        issue_wr   = 1'b0;
        issue_idx  = node_cnt;
        issue_line = line_cnt;
        issue_node = node_q;

        case (state)
            IDLE: begin
                issue_idx  = '0;
                issue_line = '0;
                if (!update_phase) begin
                    issue_node = {cur_replay_iter, issue_idx};
                    if (stream_begin || (cur_replay_iter != last_iter_q)) begin
                        issue_rd = 1'b1;
                        nx_state = STREAM;
                    end
                end else begin
                    issue_node = req_node_id;
                    if (req_valid && req_write) begin
                        issue_wr = 1'b1;
                        // Single-line burst never leaves IDLE
                        if (!req_last) begin
                            nx_state = WRITE_BACK;
                        end
                    end else if (req_valid) begin
                        issue_rd = 1'b1;
                        nx_state = READ_EDGE;
                    end
                end
            end
            STREAM: begin
                issue_node = {last_iter_q, issue_idx};
                if (beat_last_q) begin
                    nx_state = IDLE;
                end else begin
                    issue_rd = 1'b1;
                end
            end
            READ_EDGE: begin
                if (beat_last_q) begin
                    nx_state = IDLE;
                end else begin
                    issue_rd = 1'b1;
                end
            end
            WRITE_BACK: begin
                if (req_valid) begin
                    issue_wr = 1'b1;
                    if (req_last) begin
                        nx_state = IDLE;
                    end
                end
            end
            default: nx_state = IDLE;
        endcase
    end

    // Counter advance; only a stream walks across nodes
    always_comb begin
        nx_line = line_cnt;
        nx_node = node_cnt;
        if (issue_wr) begin
            nx_line = issue_line + 1'b1;
        end else if (issue_rd) begin
            if (line_last) begin
                nx_line = '0;
                nx_node = (nx_state == STREAM) ? issue_idx + 1'b1 : issue_idx;
            end else begin
                nx_line = issue_line + 1'b1;
            end
        end
    end

    assign beat_last_d = line_last &&
        ((nx_state != STREAM) || (int'(issue_idx) == NODES_PER_ITER - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= IDLE;
            line_cnt     <= '0;
            node_cnt     <= '0;
            lines_q      <= '0;
            last_iter_q  <= '0;
            beat_first_q <= 1'b0;
            beat_last_q  <= 1'b0;
        end else begin
            state    <= nx_state;
            line_cnt <= nx_line;
            node_cnt <= nx_node;
            if (state == IDLE) begin
                lines_q <= lines_in;
            end
            if ((state == IDLE) && (nx_state == STREAM)) begin
                last_iter_q <= cur_replay_iter;
            end
            if (issue_rd) begin
                beat_first_q <= (state == IDLE);
                beat_last_q  <= beat_last_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            node_q <= req_node_id;
            tag_q  <= req_pe_tag;
        end
        if (issue_rd) begin
            beat_buf_q <= {issue_idx, issue_line};
        end
    end

    // SRAM port
    assign sram_cen   = !(issue_rd || issue_wr);
    assign sram_wen   = !issue_wr;
    assign sram_addr  = {issue_node, issue_line};
    assign sram_wdata = req_data;

    // Data returned by the SRAM is forwarded in the cycle it arrives
    assign stream_valid = (state == STREAM);
    assign stream_sos   = stream_valid && beat_first_q;
    assign stream_eos   = stream_valid && beat_last_q;
    assign stream_addr  = beat_buf_q;
    assign stream_data  = sram_rdata;

    assign rd_valid = (state == READ_EDGE);
    assign rd_sos   = rd_valid && beat_first_q;
    assign rd_eos   = rd_valid && beat_last_q;
    assign rd_tag   = tag_q;
    assign rd_data  = sram_rdata;

    a_no_wr_during_rd: assert property (
        @(posedge clk) disable iff (reset)
        (!sram_cen && !sram_wen) |-> !(stream_valid || rd_valid)
    ) else $error("SRAM write while read data is being forwarded");

    a_req_not_busy: assert property (
        @(posedge clk) disable iff (reset)
        $rose(req_valid) |-> !(state inside {STREAM, READ_EDGE})
    ) else $error("request raised while the bank is busy");

    a_fv_num_nonzero: assert property (
        @(posedge clk) disable iff (reset)
        ((state == IDLE) && issue_rd) |-> (fv_num != '0)
    ) else $error("fv_num is zero at operation start");

endmodule

//--- fv_bank_tb.sv
/* Self-checking testbench for the feature-value bank. Concurrent assertions compare the DUT
   with a reference memory that is kept from the writes driven here. */
module fv_bank_tb
    import fv_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic                   clk;
    logic                   reset;
    logic                   update_phase;
    iter_t                  cur_replay_iter;
    logic                   stream_begin;
    fv_count_t              fv_num;
    logic                   req_valid;
    logic                   req_write;
    node_id_t               req_node_id;
    pe_tag_t                req_pe_tag;
    fv_line_t               req_data;
    logic                   req_last;
    buf_addr_t              sm_rd_addr;
    logic                   stream_done;
    fv_line_t               sm_rd_data;
    logic [NUM_EDGE_PE-1:0] edge_valid;
    logic                   edge_sos;
    logic                   edge_eos;
    fv_line_t               edge_data;

    // Reference memory and run bookkeeping
    fv_line_t    ref_mem [SRAM_DEPTH];
    logic [31:0] rng_state = 32'h0674_cee6;
    int          cyc = 0;
    int          errors = 0;
    int          err_mark = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    // Expected edge read window, set when a read is driven
    logic                   rd_armed = 1'b0;
    int                     rd_start = 0;
    int                     rd_lines = 0;
    node_id_t               rd_node_exp = '0;
    pe_tag_t                rd_tag_exp = '0;
    int                     edge_beat;
    logic                   edge_on;
    logic [NUM_EDGE_PE-1:0] exp_edge_valid;
    logic                   exp_edge_sos;
    logic                   exp_edge_eos;
    fv_line_t               exp_edge_data;

    // Expected stream and buffer readback
    logic     st_armed = 1'b0;
    int       st_start = 0;
    int       st_lines = 0;
    iter_t    st_iter_exp = '0;
    logic     exp_done;
    logic     sm_chk = 1'b0;
    logic     sm_exp_on;
    fv_line_t sm_exp;

    fv_bank_top fv_bank_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Number of the next rising edge
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Edge beats at T+2 .. T+L+1, done at T+4L+1
    always_comb begin
        edge_beat      = cyc - rd_start - 2;
        edge_on        = rd_armed && (edge_beat >= 0) && (edge_beat < rd_lines);
        exp_edge_valid = '0;
        if (edge_on) begin
            exp_edge_valid[rd_tag_exp] = 1'b1;
        end
        exp_edge_sos  = edge_on && (edge_beat == 0);
        exp_edge_eos  = edge_on && (edge_beat == rd_lines - 1);
        exp_edge_data = ref_mem[{rd_node_exp, line_idx_t'(edge_beat)}];
        exp_done      = st_armed && (cyc - st_start == NODES_PER_ITER * st_lines + 1);
    end

    // Buffer read data follows the address by one cycle
    always @(posedge clk) begin
        sm_exp    <= ref_mem[{st_iter_exp, sm_rd_addr}];
        sm_exp_on <= sm_chk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    a_reset_values: assert property (
        @(posedge clk) $fell(reset) |-> ((edge_valid == '0) && !stream_done)
    ) else report_mismatch("edge_valid or stream_done not low after reset");

    a_edge_valid: assert property (
        @(posedge clk) disable iff (reset) edge_valid == exp_edge_valid
    ) else report_mismatch("edge_valid differs from the expected PE and window");

    a_edge_marks: assert property (
        @(posedge clk) disable iff (reset)
        (edge_sos == exp_edge_sos) && (edge_eos == exp_edge_eos)
    ) else report_mismatch("edge_sos or edge_eos on the wrong beat");

    a_edge_data: assert property (
        @(posedge clk) disable iff (reset) edge_on |-> (edge_data == exp_edge_data)
    ) else report_mismatch("edge_data differs from the reference line");

    a_stream_done: assert property (
        @(posedge clk) disable iff (reset) stream_done == exp_done
    ) else report_mismatch("stream_done not at T+4L+1");

    a_buffer_data: assert property (
        @(posedge clk) disable iff (reset) sm_exp_on |-> (sm_rd_data == sm_exp)
    ) else report_mismatch("sm_rd_data differs from the reference line");

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        if (errors == err_mark) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // Eight-line burst; the reference follows only if the bank should take it
    task automatic write_burst(input node_id_t node, input logic taken);
        fv_line_t data;
        for (int k = 0; k < LINES_PER_NODE; k++) begin
            data        = {next_random(), next_random()};
            req_valid   = 1'b1;
            req_write   = 1'b1;
            req_node_id = node;
            req_data    = data;
            req_last    = (k == LINES_PER_NODE - 1);
            if (taken) begin
                ref_mem[{node, line_idx_t'(k)}] = data;
            end
            step_cycle();
        end
        req_valid = 1'b0;
        req_write = 1'b0;
        req_last  = 1'b0;
        step_cycle();
    endtask

    task automatic read_node(input node_id_t node, input pe_tag_t tag, input fv_count_t fv);
        int waited;
        fv_num      = fv;
        req_valid   = 1'b1;
        req_write   = 1'b0;
        req_node_id = node;
        req_pe_tag  = tag;
        rd_node_exp = node;
        rd_tag_exp  = tag;
        rd_lines    = (int'(fv) + 1) / 2;
        rd_start    = cyc;
        rd_armed    = 1'b1;
        step_cycle();
        req_valid = 1'b0;
        waited    = 0;
        while (!edge_eos && waited < LINES_PER_NODE + 4) begin
            step_cycle();
            waited++;
        end
        if (!edge_eos) begin
            errors++;
            $display("Timeout: the read of node %0d never ended with edge_eos", node);
        end
        step_cycle();
    endtask

    task automatic run_stream(input logic use_begin, input iter_t iter, input fv_count_t fv);
        int waited;
        fv_num          = fv;
        update_phase    = 1'b0;
        cur_replay_iter = iter;
        stream_begin    = use_begin;
        st_iter_exp     = iter;
        st_lines        = (int'(fv) + 1) / 2;
        st_start        = cyc;
        st_armed        = 1'b1;
        step_cycle();
        stream_begin = 1'b0;
        waited       = 0;
        while (!stream_done && waited < NODES_PER_ITER * LINES_PER_NODE + 4) begin
            step_cycle();
            waited++;
        end
        if (!stream_done) begin
            errors++;
            $display("Timeout: stream of iteration %0d never raised stream_done", iter);
        end
        step_cycle();
        // Read back every streamed line
        for (int n = 0; n < NODES_PER_ITER; n++) begin
            for (int k = 0; k < st_lines; k++) begin
                sm_rd_addr = {2'(n), line_idx_t'(k)};
                sm_chk     = 1'b1;
                step_cycle();
            end
        end
        sm_chk = 1'b0;
        step_cycle();
    endtask

    initial begin
        node_id_t  node;
        iter_t     new_iter;
        fv_count_t fv;
        reset           = 1'b1;
        update_phase    = 1'b1;
        cur_replay_iter = '0;
        stream_begin    = 1'b0;
        fv_num          = fv_count_t'(MAX_FV_NUM);
        req_valid       = 1'b0;
        req_write       = 1'b0;
        req_node_id     = '0;
        req_pe_tag      = '0;
        req_data        = '0;
        req_last        = 1'b0;
        sm_rd_addr      = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        step_cycle();
        step_cycle();
        finish_test("reset values");

        for (int n = 0; n < NUM_ITER * NODES_PER_ITER; n++) begin
            write_burst(node_id_t'(n), 1'b1);
        end
        finish_test("write-back");

        // First read uses an odd count for the rounding
        for (int k = 0; k < 4; k++) begin
            if (k == 0) begin
                fv = fv_count_t'(2 * (next_random() % 8) + 1);
            end else begin
                fv = fv_count_t'(next_random() % MAX_FV_NUM + 1);
            end
            read_node(node_id_t'(next_random()), pe_tag_t'(next_random()), fv);
        end
        finish_test("edge read");

        run_stream(1'b1, cur_replay_iter, fv_count_t'(next_random() % MAX_FV_NUM + 1));
        finish_test("stream by stream_begin");

        new_iter = iter_t'(1 + next_random() % (NUM_ITER - 1));
        run_stream(1'b0, new_iter, fv_count_t'(next_random() % MAX_FV_NUM + 1));
        finish_test("stream by iteration change");

        // Bank ignores requests outside the update phase
        node = node_id_t'(next_random());
        write_burst(node, 1'b0);
        req_valid   = 1'b1;
        req_node_id = node;
        step_cycle();
        req_valid = 1'b0;
        repeat (LINES_PER_NODE + 2) step_cycle();
        update_phase = 1'b1;
        step_cycle();
        read_node(node, pe_tag_t'(next_random()), fv_count_t'(MAX_FV_NUM));
        finish_test("dropped requests");

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- fv_bank_top.sv
/* Feature-value bank: controller, SRAM, then stream buffer or edge router.
   Callers must not issue requests while the bank is busy. */
module fv_bank_top
    import fv_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   update_phase,
    input  iter_t                  cur_replay_iter,
    input  logic                   stream_begin,
    input  fv_count_t              fv_num,
    input  logic                   req_valid,
    input  logic                   req_write,
    input  node_id_t               req_node_id,
    input  pe_tag_t                req_pe_tag,
    input  fv_line_t               req_data,
    input  logic                   req_last,
    input  buf_addr_t              sm_rd_addr,
    output logic                   stream_done,
    output fv_line_t               sm_rd_data,
    output logic [NUM_EDGE_PE-1:0] edge_valid,
    output logic                   edge_sos,
    output logic                   edge_eos,
    output fv_line_t               edge_data
);

    logic      sram_cen;
    logic      sram_wen;
    fv_addr_t  sram_addr;
    fv_line_t  sram_wdata;
    fv_line_t  sram_rdata;

    logic      stream_valid;
    logic      stream_sos;
    logic      stream_eos;
    buf_addr_t stream_addr;
    fv_line_t  stream_data;

    logic      rd_valid;
    logic      rd_sos;
    logic      rd_eos;
    pe_tag_t   rd_tag;
    fv_line_t  rd_data;

    fv_bank_ctrl fv_bank_ctrl_i (
        .clk, .reset, .update_phase, .stream_begin, .fv_num, .cur_replay_iter,
        .req_valid, .req_write, .req_last, .req_node_id, .req_pe_tag, .req_data,
        .sram_rdata, .sram_cen, .sram_wen, .sram_addr, .sram_wdata,
        .stream_valid, .stream_sos, .stream_eos, .stream_addr, .stream_data,
        .rd_valid, .rd_sos, .rd_eos, .rd_tag, .rd_data
    );

    fv_sram_bank fv_sram_bank_i (
        .clk   (clk),
        .cen   (sram_cen),
        .wen   (sram_wen),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    fv_stream_buffer fv_stream_buffer_i (
        .clk, .reset, .stream_valid, .stream_sos, .stream_eos, .stream_addr,
        .stream_data, .sm_rd_addr, .stream_done, .sm_rd_data
    );

    fv_edge_router fv_edge_router_i (
        .clk, .reset, .rd_valid, .rd_sos, .rd_eos, .rd_tag, .rd_data,
        .edge_valid, .edge_sos, .edge_eos, .edge_data
    );

endmodule

//--- fv_edge_router.sv
/* Registers each read beat and raises the valid of the tagged edge PE only.
   Adds one cycle between the controller and the PEs. */
module fv_edge_router
    import fv_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rd_valid,
    input  logic                   rd_sos,
    input  logic                   rd_eos,
    input  pe_tag_t                rd_tag,
    input  fv_line_t               rd_data,
    output logic [NUM_EDGE_PE-1:0] edge_valid,
    output logic                   edge_sos,
    output logic                   edge_eos,
    output fv_line_t               edge_data
);

    logic [NUM_EDGE_PE-1:0] tag_dec;

    // One-hot tag decode
    always_comb begin
        tag_dec = '0;
        for (int i = 0; i < NUM_EDGE_PE; i++) begin
            tag_dec[i] = rd_valid && (int'(rd_tag) == i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            edge_valid <= '0;
            edge_sos   <= 1'b0;
            edge_eos   <= 1'b0;
        end else begin
            edge_valid <= tag_dec;
            edge_sos   <= rd_valid && rd_sos;
            edge_eos   <= rd_valid && rd_eos;
        end
    end

    always_ff @(posedge clk) begin
        edge_data <= rd_data;
    end

    // Frame markers only ride on a beat for exactly one PE
    a_one_pe: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(edge_valid) && ((edge_sos || edge_eos) -> (edge_valid != '0))
    ) else $error("edge_valid not one-hot or frame marker without a beat");

endmodule

//--- fv_pkg.sv
/* Sizes and types of the feature-value bank. The address layout {node id, line}
   is shared by streaming, write-back and edge reads. */
package fv_pkg;

    // Bank geometry
    localparam int FV_WIDTH       = 64;
    localparam int MAX_FV_NUM     = 16;
    localparam int LINES_PER_NODE = MAX_FV_NUM / 2;
    localparam int NODES_PER_ITER = 4;
    localparam int NUM_ITER       = 4;
    localparam int NUM_EDGE_PE    = 4;
    localparam int SRAM_DEPTH     = 128;

    // One SRAM line holds two 32-bit feature values
    typedef logic [FV_WIDTH-1:0] fv_line_t;

    typedef logic [$clog2(NUM_ITER)-1:0] iter_t;

    // Upper bits select the iteration, lower bits the node within it
    typedef logic [$clog2(NUM_ITER*NODES_PER_ITER)-1:0] node_id_t;

    typedef logic [$clog2(LINES_PER_NODE)-1:0] line_idx_t;

    // {node_id_t, line_idx_t}
    typedef logic [$clog2(SRAM_DEPTH)-1:0] fv_addr_t;

    // Feature count, 1 to MAX_FV_NUM
    typedef logic [$clog2(MAX_FV_NUM):0] fv_count_t;

    typedef logic [$clog2(NUM_EDGE_PE)-1:0] pe_tag_t;

    // {node within iteration, line_idx_t}
    typedef logic [$clog2(NODES_PER_ITER*LINES_PER_NODE)-1:0] buf_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        STREAM,
        WRITE_BACK,
        READ_EDGE
    } bank_state_t;

endpackage

//--- fv_sram_bank.sv
/* Behavioral single-port SRAM, enables active low, read data one cycle after the
   access. Contents are not initialized; a write leaves rdata unchanged. */
module fv_sram_bank
    import fv_pkg::*;
(
    input  logic     clk,
    input  logic     cen,
    input  logic     wen,
    input  fv_addr_t addr,
    input  fv_line_t wdata,
    output fv_line_t rdata
);

    fv_line_t mem [SRAM_DEPTH];

    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[addr] <= wdata;
            end else begin
                // Registered read
                rdata <= mem[addr];
            end
        end
    end

    // Controller must present a clean address whenever the bank is selected
    a_addr_known: assert property (
        @(posedge clk) !cen |-> !$isunknown(addr)
    ) else $error("SRAM accessed with unknown address bits");

endmodule

//--- fv_stream_buffer.sv
/* Holds one streamed iteration. Beats outside an sos..eos frame are ignored,
   and sm_rd_data follows sm_rd_addr by one cycle. */
module fv_stream_buffer
    import fv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      stream_valid,
    input  logic      stream_sos,
    input  logic      stream_eos,
    input  buf_addr_t stream_addr,
    input  fv_line_t  stream_data,
    input  buf_addr_t sm_rd_addr,
    output logic      stream_done,
    output fv_line_t  sm_rd_data
);

    fv_line_t mem [NODES_PER_ITER*LINES_PER_NODE];

    logic open_q;
    logic beat_ok;

    // Beat belongs to a framed stream
    assign beat_ok = stream_valid && (stream_sos || open_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            open_q      <= 1'b0;
            stream_done <= 1'b0;
        end else begin
            stream_done <= beat_ok && stream_eos;
            if (beat_ok && stream_eos) begin
                open_q <= 1'b0;
            end else if (beat_ok && stream_sos) begin
                open_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_ok) begin
            mem[stream_addr] <= stream_data;
        end
        sm_rd_data <= mem[sm_rd_addr];
    end

    a_framed: assert property (
        @(posedge clk) disable iff (reset)
        stream_valid |-> (stream_sos ? !open_q : open_q)
    ) else $error("stream beat outside a framed stream");

endmodule

//--- src.f
fv_pkg.sv
fv_sram_bank.sv
fv_bank_ctrl.sv
fv_stream_buffer.sv
fv_edge_router.sv
fv_bank_top.sv
fv_bank_tb.sv
